/* all.f */
rtl/cpu_pkg.sv
rtl/cpu_state_machine.sv
rtl/inst_mem_read.sv
rtl/decoder.sv
rtl/register_file.sv
rtl/execution.sv
rtl/write_back.sv
rtl/cpu_top.sv
verification/cpu_top_asserts.sv
verification/tb_cpu_top.sv

/* run.sh */
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal --top-module tb_cpu_top -f all.f -o sim_cpu_top &&
	./obj_dir/sim_cpu_top +verilator+error+limit+100 | tee /dev/stderr |
	grep "STATUS: PASS" > /dev/null &&
	echo "run.sh: simulation passed" ||
	{ echo "run.sh: simulation failed"; exit 1; }

/* verification/tb_cpu_top.sv */
module tb_cpu_top;
	import cpu_pkg::*;

	localparam int MAX_PROG  = 48;
	localparam int K_RETIRE  = 0;
	localparam int K_ILLEGAL = 1;
	localparam int K_QUIT    = 2; // quit raised while this one is fetched

	logic            clk;
	logic            i_arst_n;
	logic            i_cpu_start;
	logic [XLEN-1:2] i_cpu_start_adr;
	logic            i_quit_cmd;
	logic            o_cpu_run_state;
	logic [XLEN-1:0] o_pc_data;
	logic            o_i_read_req;
	logic [XLEN-1:0] o_i_read_adr;
	logic            i_read_valid;
	logic [XLEN-1:0] i_read_data;
	logic            o_illegal_ops;
	logic            o_wbk_valid;
	logic [4:0]      o_wbk_rd;
	logic [XLEN-1:0] o_wbk_data;

	string           t_name  [MAX_PROG];
	int              t_kind  [MAX_PROG];
	bit              t_start [MAX_PROG];
	logic [XLEN-1:2] t_pc    [MAX_PROG];
	logic [4:0]      t_rd    [MAX_PROG];
	logic [XLEN-1:0] t_data  [MAX_PROG];
	logic [XLEN-1:0] imem    [int unsigned]; // word address to instruction
	int              n_prog;
	int              n_checks;
	int              n_errors;
	logic [XLEN-1:2] cur_pc;
	bit              start_pending;
	bit              table_ready;
	integer          seed = 32'hf411;

	cpu_top #(.REG_NUM(32)) DUT (.*);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic check_data(input string name, input logic [XLEN-1:0] exp,
		input logic [XLEN-1:0] act);
		n_checks++;
		if (act !== exp) begin
			n_errors++;
			$display("[FAIL] %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic check_pc(input string name, input logic [XLEN-1:2] exp,
		input logic [XLEN-1:2] act);
		n_checks++;
		if (act !== exp) begin
			n_errors++;
			$display("[FAIL] %s expected word %h actual word %h", name, exp, act);
		end
	endtask

	task automatic check_rd(input string name, input logic [4:0] exp, input logic [4:0] act);
		n_checks++;
		if (act !== exp) begin
			n_errors++;
			$display("[FAIL] %s expected x%0d actual x%0d", name, exp, act);
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		n_checks++;
		if (act !== exp) begin
			n_errors++;
			$display("[FAIL] %s expected %b actual %b", name, exp, act);
		end
	endtask

	function automatic logic [XLEN-1:0] encode_r(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, OP_ALU};
	endfunction

	function automatic logic [XLEN-1:0] encode_i(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [XLEN-1:0] encode_b(input logic [12:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BR};
	endfunction

	function automatic logic [XLEN-1:0] encode_jal(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
	endfunction

	task automatic begin_run(input logic [XLEN-1:2] adr);
		cur_pc        = adr;
		start_pending = 1'b1;
	endtask

	task automatic add_entry(input string name, input int kind, input logic [XLEN-1:0] inst,
		input logic [4:0] rd, input logic [XLEN-1:0] data, input logic [XLEN-1:2] next);
		t_name[n_prog]  = name;
		t_kind[n_prog]  = kind;
		t_start[n_prog] = start_pending;
		t_pc[n_prog]    = cur_pc;
		t_rd[n_prog]    = rd;
		t_data[n_prog]  = data;
		imem[cur_pc]    = inst;
		start_pending   = 1'b0;
		cur_pc          = next; // where the following entry must be fetched
		n_prog++;
	endtask

	task automatic add_seq(input string name, input logic [XLEN-1:0] inst, input logic [4:0] rd,
		input logic [XLEN-1:0] data);
		add_entry(name, K_RETIRE, inst, rd, data, cur_pc + 30'd1);
	endtask

	task automatic build_program();
		begin_run(30'h10);
		add_seq("addi x1", encode_i(12'd5, 0, 3'b000, 1, OP_ALUI), 1, 32'd5);
		add_seq("addi x2", encode_i(12'hffd, 0, 3'b000, 2, OP_ALUI), 2, 32'hffff_fffd);
		add_seq("add", encode_r(7'h00, 2, 1, 3'b000, 3), 3, 32'd2);
		add_seq("sub", encode_r(7'h20, 1, 2, 3'b000, 4), 4, 32'hffff_fff8);
		add_seq("sra", encode_r(7'h20, 1, 4, 3'b101, 5), 5, 32'hffff_ffff);
		add_seq("srl", encode_r(7'h00, 1, 4, 3'b101, 6), 6, 32'h07ff_ffff);
		add_seq("slt", encode_r(7'h00, 1, 2, 3'b010, 7), 7, 32'd1);
		add_seq("sltu", encode_r(7'h00, 1, 2, 3'b011, 8), 8, 32'd0);
		add_seq("sll", encode_r(7'h00, 1, 1, 3'b001, 9), 9, 32'h0000_00a0);
		add_seq("xor", encode_r(7'h00, 2, 1, 3'b100, 10), 10, 32'hffff_fff8);
		add_seq("or", encode_r(7'h00, 2, 1, 3'b110, 11), 11, 32'hffff_fffd);
		add_seq("and", encode_r(7'h00, 2, 1, 3'b111, 12), 12, 32'd5);
		add_seq("xori", encode_i(12'h0f0, 1, 3'b100, 13, OP_ALUI), 13, 32'h0000_00f5);
		add_seq("slti", encode_i(12'hffe, 2, 3'b010, 14, OP_ALUI), 14, 32'd1);
		add_seq("sltiu", encode_i(12'hfff, 1, 3'b011, 15, OP_ALUI), 15, 32'd1);
		add_seq("srai", encode_i(12'h401, 2, 3'b101, 16, OP_ALUI), 16, 32'hffff_fffe);
		add_seq("slli", encode_i(12'h003, 1, 3'b001, 17, OP_ALUI), 17, 32'h0000_0028);
		add_seq("andi", encode_i(12'h0ff, 2, 3'b111, 18, OP_ALUI), 18, 32'h0000_00fd);
		add_seq("ori", encode_i(12'h100, 1, 3'b110, 19, OP_ALUI), 19, 32'h0000_0105);
		add_seq("lui", {20'h12345, 5'd20, OP_LUI}, 20, 32'h1234_5000);
		add_seq("auipc", {20'h00001, 5'd21, OP_AUIPC}, 21, 32'h0000_1090); // pc byte 0x90
		add_seq("addi x0", encode_i(12'd7, 1, 3'b000, 0, OP_ALUI), 0, 32'd0); // nothing written
		add_seq("or x0 x0", encode_r(7'h00, 0, 0, 3'b110, 22), 22, 32'd0);
		add_entry("jal", K_RETIRE, encode_jal(21'd16, 23), 23, 32'h0000_00a0, 30'h2b);
		add_entry("beq taken", K_RETIRE, encode_b(13'd8, 12, 1, 3'b000), 0, 32'd0, 30'h2d);
		add_seq("bne untaken", encode_b(13'd8, 12, 1, 3'b001), 0, 32'd0);
		add_entry("blt taken", K_RETIRE, encode_b(13'd8, 1, 2, 3'b100), 0, 32'd0, 30'h30);
		add_seq("bltu untaken", encode_b(13'd8, 1, 2, 3'b110), 0, 32'd0);
		add_entry("bgeu taken", K_RETIRE, encode_b(13'd12, 1, 2, 3'b111), 0, 32'd0, 30'h34);
		add_seq("bge untaken", encode_b(13'd8, 1, 2, 3'b101), 0, 32'd0);
		// 0x28 + 0xb9 has bit 0 set so the target lands on byte 0xe0
		add_entry("jalr", K_RETIRE, encode_i(12'h0b9, 17, 3'b000, 24, OP_JALR), 24,
			32'h0000_00d8, 30'h38);
		add_seq("addi link", encode_i(12'd4, 24, 3'b000, 25, OP_ALUI), 25, 32'h0000_00dc);
		add_seq("illegal funct7", encode_r(7'h01, 1, 1, 3'b000, 26), 0, 32'd0);
		t_kind[n_prog-1] = K_ILLEGAL;
		begin_run(30'h80);
		add_seq("quit addi", encode_i(12'h050, 1, 3'b000, 26, OP_ALUI), 26, 32'h0000_0055);
		t_kind[n_prog-1] = K_QUIT;
	endtask

	task automatic start_core(input logic [XLEN-1:2] adr);
		@(negedge clk);
		i_cpu_start     = 1'b1;
		i_cpu_start_adr = adr;
		@(negedge clk);
		i_cpu_start = 1'b0;
		check_bit("run state after start", 1'b1, o_cpu_run_state);
	endtask

	task automatic check_stopped(input string name);
		int extra;
		extra = 0;
		@(negedge clk);
		check_bit({name, " run state"}, 1'b0, o_cpu_run_state);
		check_bit({name, " no retire after stop"}, 1'b0, o_wbk_valid);
		i_quit_cmd = 1'b0;
		repeat (10) begin
			@(negedge clk);
			if (o_wbk_valid || o_illegal_ops || o_i_read_req)
				extra++;
		end
		if (extra != 0) begin
			n_errors++;
			$display("%s: core kept fetching or retiring after it stopped", name);
		end
	endtask

	// instruction memory answering each request after 1 to 4 cycles
	initial begin : imem_model
		int lat;
		i_read_valid = 1'b0;
		i_read_data  = '0;
		forever begin
			@(negedge clk);
			if (o_i_read_req) begin
				lat = 1 + int'($unsigned($random(seed)) % 4);
				repeat (lat - 1) @(negedge clk);
				if (!imem.exists(o_i_read_adr[XLEN-1:2])) begin
					n_errors++;
					$display("fetch from address %h that holds no program word", o_i_read_adr);
				end
				i_read_valid = 1'b1;
				i_read_data  = imem.exists(o_i_read_adr[XLEN-1:2]) ?
					imem[o_i_read_adr[XLEN-1:2]] : '0;
				@(negedge clk);
				i_read_valid = 1'b0;
			end
		end
	end

	initial begin : watchdog
		wait (table_ready);
		repeat (n_prog * 20) @(posedge clk);
		$display("watchdog expired, the program did not finish in %0d cycles", n_prog * 20);
		$display("checks: %0d, errors: %0d", n_checks, n_errors + 1);
		$display("STATUS: FAIL");
		$finish;
	end

	initial begin : main
		i_arst_n        = 1'b0;
		i_cpu_start     = 1'b0;
		i_cpu_start_adr = '0;
		i_quit_cmd      = 1'b0;
		n_prog          = 0;
		n_checks        = 0;
		n_errors        = 0;
		build_program();
		table_ready = 1'b1;
		repeat (2) @(negedge clk);
		i_arst_n = 1'b1;
		@(negedge clk);
		check_bit("reset run state", 1'b0, o_cpu_run_state);
		check_bit("reset read req", 1'b0, o_i_read_req);
		check_bit("reset wbk valid", 1'b0, o_wbk_valid);
		check_bit("reset illegal", 1'b0, o_illegal_ops);
		for (int i = 0; i < n_prog; i++) begin
			if (t_start[i])
				start_core(t_pc[i]);
			while (!o_i_read_req)
				@(negedge clk);
			if (t_start[i])
				check_data({t_name[i], " first fetch byte address"}, {t_pc[i], 2'b00}, o_i_read_adr);
			check_pc({t_name[i], " fetch address"}, t_pc[i], o_i_read_adr[XLEN-1:2]);
			check_data({t_name[i], " pc output"}, {t_pc[i], 2'b00}, o_pc_data);
			if (t_kind[i] == K_QUIT)
				i_quit_cmd = 1'b1;
			do @(negedge clk); while (!o_wbk_valid && !o_illegal_ops);
			if (t_kind[i] == K_ILLEGAL) begin
				check_bit({t_name[i], " illegal pulse"}, 1'b1, o_illegal_ops);
			end else begin
				check_bit({t_name[i], " retire"}, 1'b1, o_wbk_valid);
				check_rd({t_name[i], " rd"}, t_rd[i], o_wbk_rd);
				check_data({t_name[i], " data"}, t_data[i], o_wbk_data);
			end
			if (t_kind[i] != K_RETIRE)
				check_stopped(t_name[i]);
		end
		if (DUT.u_asserts.n_fail != 0) begin
			n_errors += DUT.u_asserts.n_fail;
			$display("bound assertions failed %0d time(s)", DUT.u_asserts.n_fail);
		end
		$display("checks: %0d, errors: %0d", n_checks, n_errors);
		if (n_errors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

/* verification/cpu_top_asserts.sv */
module cpu_top_asserts (
	input logic                clk,
	input logic                i_arst_n,
	input logic                i_read_req,
	input logic                i_read_valid,
	input logic                i_wbk_valid,
	input cpu_pkg::cpu_state_t i_state
);
	import cpu_pkg::*;

	int n_fail = 0; // failures seen so far

	function automatic logic step_ok(input cpu_state_t prev, input cpu_state_t cur);
		case (prev)
			ST_PC:    return cur inside {ST_PC, ST_IMR};
			ST_IMR:   return cur inside {ST_IMR, ST_IDRFR};
			ST_IDRFR: return cur == ST_EX;
			ST_EX:    return cur inside {ST_WB, ST_PC}; // illegal skips WB
			default:  return cur == ST_PC;
		endcase
	endfunction

	req_held: assert property (@(posedge clk) disable iff (!i_arst_n)
		(i_read_req && !i_read_valid) |=> i_read_req)
		else begin
			$error("fetch request dropped before the valid strobe");
			n_fail++;
		end

	wbk_single: assert property (@(posedge clk) disable iff (!i_arst_n)
		i_wbk_valid |=> !i_wbk_valid)
		else begin
			$error("retire strobe high in two consecutive cycles");
			n_fail++;
		end

	state_order: assert property (@(posedge clk) disable iff (!i_arst_n)
		step_ok($past(i_state), i_state))
		else begin
			$error("state left the instruction sequence order");
			n_fail++;
		end

endmodule

bind cpu_top cpu_top_asserts u_asserts (
	.clk          (clk),
	.i_arst_n     (i_arst_n),
	.i_read_req   (o_i_read_req),
	.i_read_valid (i_read_valid),
	.i_wbk_valid  (o_wbk_valid),
	.i_state      (state)
);

/* rtl/cpu_top.sv */
interface dec_if;
	import cpu_pkg::*;

	logic [4:0]      rd_adr;
	logic [4:0]      rs1_adr;
	logic [4:0]      rs2_adr;
	logic [XLEN-1:0] imm; // sign-extended for every format
	alu_op_t         alu_op;
	logic            cmd_lui;
	logic            cmd_auipc;
	logic            cmd_jal;
	logic            cmd_jalr;
	logic            cmd_br;
	logic            cmd_alui;
	br_code_t        br_code;
	logic            wbk_rd_reg;
	logic            illegal;

	modport dec (
		output rd_adr, rs1_adr, rs2_adr, imm, alu_op, cmd_lui, cmd_auipc,
		output cmd_jal, cmd_jalr, cmd_br, cmd_alui, br_code, wbk_rd_reg, illegal
	);
	modport exe (
		input imm, alu_op, cmd_lui, cmd_auipc, cmd_jal, cmd_jalr, cmd_br, cmd_alui, br_code
	);
	modport res (
		input rd_adr, wbk_rd_reg, illegal
	);
endinterface

module cpu_top #(
	parameter int REG_NUM = 32
) (
	input  logic                     clk,
	input  logic                     i_arst_n,
	input  logic                     i_cpu_start,
	input  logic [cpu_pkg::XLEN-1:2] i_cpu_start_adr,
	input  logic                     i_quit_cmd,
	output logic                     o_cpu_run_state,
	output logic [cpu_pkg::XLEN-1:0] o_pc_data,
	output logic                     o_i_read_req,
	output logic [cpu_pkg::XLEN-1:0] o_i_read_adr,
	input  logic                     i_read_valid,
	input  logic [cpu_pkg::XLEN-1:0] i_read_data,
	output logic                     o_illegal_ops,
	output logic                     o_wbk_valid,
	output logic [4:0]               o_wbk_rd,
	output logic [cpu_pkg::XLEN-1:0] o_wbk_data
);
	import cpu_pkg::*;

	cpu_state_t      state;
	logic            imr_run;
	logic [XLEN-1:2] pc;
	logic [XLEN-1:2] next_pc;
	logic            pc_load;
	logic [XLEN-1:0] inst;
	logic [XLEN-1:0] rs1_data;
	logic [XLEN-1:0] rs2_data;
	logic [XLEN-1:0] rd_data;
	logic [XLEN-1:2] jmp_adr;
	logic            jmp_condition;
	logic            rf_we;
	logic [XLEN-1:0] rf_wdata;

	dec_if dec_bus ();

	assign o_pc_data     = {pc, 2'b00};
	assign o_illegal_ops = (state == ST_EX) && dec_bus.illegal; // single EX cycle

	cpu_state_machine u_state_machine (
		.clk             (clk),
		.i_arst_n        (i_arst_n),
		.i_cpu_start     (i_cpu_start),
		.i_quit_cmd      (i_quit_cmd),
		.i_imr_run       (imr_run),
		.i_illegal       (dec_bus.illegal),
		.o_cpu_run_state (o_cpu_run_state),
		.o_state         (state)
	);

	inst_mem_read u_inst_mem_read (
		.clk             (clk),
		.i_arst_n        (i_arst_n),
		.i_state         (state),
		.i_cpu_start     (i_cpu_start),
		.i_cpu_start_adr (i_cpu_start_adr),
		.i_next_pc       (next_pc),
		.i_pc_load       (pc_load),
		.i_read_valid    (i_read_valid),
		.i_read_data     (i_read_data),
		.o_imr_run       (imr_run),
		.o_i_read_req    (o_i_read_req),
		.o_i_read_adr    (o_i_read_adr),
		.o_pc            (pc),
		.o_inst          (inst)
	);

	decoder #(.REG_NUM(REG_NUM)) u_decoder (
		.i_inst (inst),
		.dec    (dec_bus.dec)
	);

	register_file #(.REG_NUM(REG_NUM)) u_register_file (
		.clk        (clk),
		.i_arst_n   (i_arst_n),
		.i_state    (state),
		.i_rs1_adr  (dec_bus.rs1_adr),
		.i_rs2_adr  (dec_bus.rs2_adr),
		.i_rd_adr   (dec_bus.rd_adr),
		.i_we       (rf_we),
		.i_wdata    (rf_wdata),
		.o_rs1_data (rs1_data),
		.o_rs2_data (rs2_data)
	);

	execution u_execution (
		.clk             (clk),
		.i_arst_n        (i_arst_n),
		.i_state         (state),
		.i_pc            (pc),
		.i_rs1_data      (rs1_data),
		.i_rs2_data      (rs2_data),
		.dec             (dec_bus.exe),
		.o_rd_data       (rd_data),
		.o_jmp_adr       (jmp_adr),
		.o_jmp_condition (jmp_condition)
	);

	write_back u_write_back (
		.clk             (clk),
		.i_arst_n        (i_arst_n),
		.i_state         (state),
		.i_pc            (pc),
		.i_rd_data       (rd_data),
		.i_jmp_adr       (jmp_adr),
		.i_jmp_condition (jmp_condition),
		.dec             (dec_bus.res),
		.o_rf_we         (rf_we),
		.o_rf_wdata      (rf_wdata),
		.o_next_pc       (next_pc),
		.o_pc_load       (pc_load),
		.o_wbk_valid     (o_wbk_valid),
		.o_wbk_rd        (o_wbk_rd),
		.o_wbk_data      (o_wbk_data)
	);

endmodule

/* rtl/write_back.sv */
module write_back (
	input  logic                     clk,
	input  logic                     i_arst_n,
	input  cpu_pkg::cpu_state_t      i_state,
	input  logic [cpu_pkg::XLEN-1:2] i_pc,
	input  logic [cpu_pkg::XLEN-1:0] i_rd_data,
	input  logic [cpu_pkg::XLEN-1:2] i_jmp_adr,
	input  logic                     i_jmp_condition,
	dec_if.res                       dec,
	output logic                     o_rf_we,
	output logic [cpu_pkg::XLEN-1:0] o_rf_wdata,
	output logic [cpu_pkg::XLEN-1:2] o_next_pc,
	output logic                     o_pc_load,
	output logic                     o_wbk_valid,
	output logic [4:0]               o_wbk_rd,
	output logic [cpu_pkg::XLEN-1:0] o_wbk_data
);
	import cpu_pkg::*;

	logic       retire;
	logic       wr_en;
	logic       retire_r;
	logic       we_r;
	logic [4:0] rd_r;

	assign retire = (i_state == ST_EX) && !dec.illegal; // illegal never reaches WB
	assign wr_en  = retire && dec.wbk_rd_reg && (dec.rd_adr != 5'd0);

	// flags set at the end of EX are high for exactly the WB cycle
	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			retire_r <= 1'b0;
			we_r     <= 1'b0;
			rd_r     <= '0;
		end else begin
			retire_r <= retire;
			we_r     <= wr_en;
			rd_r     <= wr_en ? dec.rd_adr : 5'd0;
		end
	end

	assign o_rf_we     = we_r;
	assign o_rf_wdata  = i_rd_data;
	assign o_next_pc   = i_jmp_condition ? i_jmp_adr : i_pc + (XLEN-2)'(1);
	assign o_pc_load   = retire_r;
	assign o_wbk_valid = retire_r;
	assign o_wbk_rd    = rd_r;
	assign o_wbk_data  = we_r ? i_rd_data : '0; // zero when nothing is written

endmodule

/* rtl/execution.sv */
module execution (
	input  logic                     clk,
	input  logic                     i_arst_n,
	input  cpu_pkg::cpu_state_t      i_state,
	input  logic [cpu_pkg::XLEN-1:2] i_pc,
	input  logic [cpu_pkg::XLEN-1:0] i_rs1_data,
	input  logic [cpu_pkg::XLEN-1:0] i_rs2_data,
	dec_if.exe                       dec,
	output logic [cpu_pkg::XLEN-1:0] o_rd_data,
	output logic [cpu_pkg::XLEN-1:2] o_jmp_adr,
	output logic                     o_jmp_condition
);
	import cpu_pkg::*;

	logic [XLEN-1:0] pc_byte;
	logic [XLEN-1:0] op_b;
	logic [XLEN-1:0] alu_res;
	logic [XLEN-1:0] result;
	logic [XLEN-1:0] target;
	logic            br_taken;
	logic            jmp_cond;

	assign pc_byte = {i_pc, 2'b00};
	assign op_b    = dec.cmd_alui ? dec.imm : i_rs2_data;

	always_comb begin
		case (dec.alu_op)
			ALU_ADD:  alu_res = i_rs1_data + op_b;
			ALU_SUB:  alu_res = i_rs1_data - op_b;
			ALU_SLL:  alu_res = i_rs1_data << op_b[4:0];
			ALU_SLT:  alu_res = ($signed(i_rs1_data) < $signed(op_b)) ? XLEN'(1) : '0;
			ALU_SLTU: alu_res = (i_rs1_data < op_b) ? XLEN'(1) : '0;
			ALU_XOR:  alu_res = i_rs1_data ^ op_b;
			ALU_SRL:  alu_res = i_rs1_data >> op_b[4:0];
			ALU_SRA:  alu_res = $unsigned($signed(i_rs1_data) >>> op_b[4:0]);
			ALU_OR:   alu_res = i_rs1_data | op_b;
			default:  alu_res = i_rs1_data & op_b;
		endcase
	end

	always_comb begin
		if (dec.cmd_lui)
			result = dec.imm;
		else if (dec.cmd_auipc)
			result = pc_byte + dec.imm;
		else if (dec.cmd_jal || dec.cmd_jalr)
			result = pc_byte + XLEN'(4); // link value
		else
			result = alu_res;
	end

	always_comb begin
		case (dec.br_code)
			BR_EQ:   br_taken = (i_rs1_data == i_rs2_data);
			BR_NE:   br_taken = (i_rs1_data != i_rs2_data);
			BR_LT:   br_taken = ($signed(i_rs1_data) < $signed(i_rs2_data));
			BR_GE:   br_taken = ($signed(i_rs1_data) >= $signed(i_rs2_data));
			BR_LTU:  br_taken = (i_rs1_data < i_rs2_data);
			BR_GEU:  br_taken = (i_rs1_data >= i_rs2_data);
			default: br_taken = 1'b0;
		endcase
	end

	// jalr is rs1 relative with bit 0 cleared, the rest pc relative
	assign target   = dec.cmd_jalr ? ((i_rs1_data + dec.imm) & ~XLEN'(1)) : (pc_byte + dec.imm);
	assign jmp_cond = dec.cmd_jal || dec.cmd_jalr || (dec.cmd_br && br_taken);

	always_ff @(posedge clk) begin
		if (i_state == ST_EX) begin
			o_rd_data <= result;
			o_jmp_adr <= target[XLEN-1:2];
		end
	end

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n)
			o_jmp_condition <= 1'b0;
		else if (i_state == ST_EX)
			o_jmp_condition <= jmp_cond;
	end

endmodule

/* rtl/register_file.sv */
module register_file #(
	parameter int REG_NUM = 32
) (
	input  logic                     clk,
	input  logic                     i_arst_n,
	input  cpu_pkg::cpu_state_t      i_state,
	input  logic [4:0]               i_rs1_adr,
	input  logic [4:0]               i_rs2_adr,
	input  logic [4:0]               i_rd_adr,
	input  logic                     i_we,
	input  logic [cpu_pkg::XLEN-1:0] i_wdata,
	output logic [cpu_pkg::XLEN-1:0] o_rs1_data,
	output logic [cpu_pkg::XLEN-1:0] o_rs2_data
);
	import cpu_pkg::*;

	localparam int AW = $clog2(REG_NUM);

	logic [XLEN-1:0] regs [REG_NUM];

	always_ff @(posedge clk) begin
		if (i_we)
			regs[i_rd_adr[AW-1:0]] <= i_wdata;
	end

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_rs1_data <= '0;
			o_rs2_data <= '0;
		end else if (i_state == ST_IDRFR) begin
			o_rs1_data <= (i_rs1_adr == 5'd0) ? '0 : regs[i_rs1_adr[AW-1:0]]; // x0 is zero
			o_rs2_data <= (i_rs2_adr == 5'd0) ? '0 : regs[i_rs2_adr[AW-1:0]];
		end
	end

endmodule

/* rtl/decoder.sv */
module decoder #(
	parameter int REG_NUM = 32
) (
	input  logic [cpu_pkg::XLEN-1:0] i_inst,
	dec_if.dec                       dec
);
	import cpu_pkg::*;

	localparam logic [5:0] REG_LIM = 6'(REG_NUM);

	logic [6:0]      opcode;
	logic [2:0]      funct3;
	logic [6:0]      funct7;
	logic [XLEN-1:0] imm_i;
	logic [XLEN-1:0] imm_u;
	logic [XLEN-1:0] imm_j;
	logic [XLEN-1:0] imm_b;
	logic            f7_reg_ok;
	logic            shift_bad;
	logic            use_rs1;
	logic            use_rs2;
	logic            bad_op;
	logic            bad_reg;

	assign opcode = i_inst[6:0];
	assign funct3 = i_inst[14:12];
	assign funct7 = i_inst[31:25];
	assign dec.rd_adr  = i_inst[11:7];
	assign dec.rs1_adr = i_inst[19:15];
	assign dec.rs2_adr = i_inst[24:20];
	assign dec.br_code = br_code_t'(funct3);

	assign imm_i = {{(XLEN-12){i_inst[31]}}, i_inst[31:20]};
	assign imm_u = {i_inst[31:12], 12'b0};
	assign imm_j = {{(XLEN-20){i_inst[31]}}, i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};
	assign imm_b = {{(XLEN-12){i_inst[31]}}, i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};

	// only ADD/SUB and SRL/SRA have an alternate funct7
	assign f7_reg_ok = (funct7 == 7'h00) ||
		((funct7 == 7'h20) && ((funct3 == 3'b000) || (funct3 == 3'b101)));
	assign shift_bad = ((funct3 == 3'b001) && (funct7 != 7'h00)) ||
		((funct3 == 3'b101) && (funct7 != 7'h00) && (funct7 != 7'h20));

	always_comb begin
		case (funct3)
			3'b000:  dec.alu_op = ((opcode == OP_ALU) && funct7[5]) ? ALU_SUB : ALU_ADD;
			3'b001:  dec.alu_op = ALU_SLL;
			3'b010:  dec.alu_op = ALU_SLT;
			3'b011:  dec.alu_op = ALU_SLTU;
			3'b100:  dec.alu_op = ALU_XOR;
			3'b101:  dec.alu_op = funct7[5] ? ALU_SRA : ALU_SRL;
			3'b110:  dec.alu_op = ALU_OR;
			default: dec.alu_op = ALU_AND;
		endcase
	end

	always_comb begin
		dec.imm        = '0;
		dec.cmd_lui    = 1'b0;
		dec.cmd_auipc  = 1'b0;
		dec.cmd_jal    = 1'b0;
		dec.cmd_jalr   = 1'b0;
		dec.cmd_br     = 1'b0;
		dec.cmd_alui   = 1'b0;
		dec.wbk_rd_reg = 1'b0;
		use_rs1        = 1'b0;
		use_rs2        = 1'b0;
		bad_op         = 1'b0;
		case (opcode)
			OP_LUI: begin
				dec.cmd_lui    = 1'b1;
				dec.imm        = imm_u;
				dec.wbk_rd_reg = 1'b1;
			end
			OP_AUIPC: begin
				dec.cmd_auipc  = 1'b1;
				dec.imm        = imm_u;
				dec.wbk_rd_reg = 1'b1;
			end
			OP_JAL: begin
				dec.cmd_jal    = 1'b1;
				dec.imm        = imm_j;
				dec.wbk_rd_reg = 1'b1;
			end
			OP_JALR: begin
				dec.cmd_jalr   = 1'b1;
				dec.imm        = imm_i;
				dec.wbk_rd_reg = 1'b1;
				use_rs1        = 1'b1;
				bad_op         = (funct3 != 3'b000);
			end
			OP_BR: begin
				dec.cmd_br = 1'b1;
				dec.imm    = imm_b;
				use_rs1    = 1'b1;
				use_rs2    = 1'b1;
				bad_op     = (funct3[2:1] == 2'b01); // 010 and 011 unused
			end
			OP_ALUI: begin
				dec.cmd_alui   = 1'b1;
				dec.imm        = imm_i;
				dec.wbk_rd_reg = 1'b1;
				use_rs1        = 1'b1;
				bad_op         = shift_bad;
			end
			OP_ALU: begin
				dec.wbk_rd_reg = 1'b1;
				use_rs1        = 1'b1;
				use_rs2        = 1'b1;
				bad_op         = !f7_reg_ok;
			end
			default: bad_op = 1'b1;
		endcase
	end

	// registers beyond REG_NUM do not exist in a reduced build
	assign bad_reg = (dec.wbk_rd_reg && ({1'b0, dec.rd_adr} >= REG_LIM)) ||
		(use_rs1 && ({1'b0, dec.rs1_adr} >= REG_LIM)) ||
		(use_rs2 && ({1'b0, dec.rs2_adr} >= REG_LIM));
	assign dec.illegal = bad_op || bad_reg;

endmodule

/* rtl/inst_mem_read.sv */
module inst_mem_read (
	input  logic                         clk,
	input  logic                         i_arst_n,
	input  cpu_pkg::cpu_state_t          i_state,
	input  logic                         i_cpu_start,
	input  logic [cpu_pkg::XLEN-1:2]     i_cpu_start_adr,
	input  logic [cpu_pkg::XLEN-1:2]     i_next_pc,
	input  logic                         i_pc_load,
	input  logic                         i_read_valid,
	input  logic [cpu_pkg::XLEN-1:0]     i_read_data,
	output logic                         o_imr_run,
	output logic                         o_i_read_req,
	output logic [cpu_pkg::XLEN-1:0]     o_i_read_adr,
	output logic [cpu_pkg::XLEN-1:2]     o_pc,
	output logic [cpu_pkg::XLEN-1:0]     o_inst
);
	import cpu_pkg::*;

	logic [XLEN-1:2] pc_r;
	logic [XLEN-1:0] inst_r;
	logic            in_imr;

	assign in_imr = (i_state == ST_IMR);

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n)
			pc_r <= '0;
		else if (i_cpu_start)
			pc_r <= i_cpu_start_adr; // start address wins
		else if (i_pc_load)
			pc_r <= i_next_pc;
	end

	always_ff @(posedge clk) begin
		if (in_imr && i_read_valid)
			inst_r <= i_read_data; // held until the next fetch
	end

	assign o_i_read_req = in_imr; // level until the valid strobe
	assign o_imr_run    = in_imr && !i_read_valid;
	assign o_i_read_adr = {pc_r, 2'b00};
	assign o_pc         = pc_r;
	assign o_inst       = inst_r;

endmodule

/* rtl/cpu_state_machine.sv */
module cpu_state_machine (
	input  logic                clk,
	input  logic                i_arst_n,
	input  logic                i_cpu_start,
	input  logic                i_quit_cmd,
	input  logic                i_imr_run,
	input  logic                i_illegal,
	output logic                o_cpu_run_state,
	output cpu_pkg::cpu_state_t o_state
);
	import cpu_pkg::*;

	logic       run_r;
	logic       quit_r;
	logic       stop_wb;
	logic       stop_ill;
	cpu_state_t state_r;
	cpu_state_t state_nxt;

	assign stop_wb  = (state_r == ST_WB) && (quit_r || i_quit_cmd); // finish current inst first
	assign stop_ill = (state_r == ST_EX) && i_illegal; // no write-back

	always_comb begin
		case (state_r)
			ST_PC:    state_nxt = run_r ? ST_IMR : ST_PC; // idle here when stopped
			ST_IMR:   state_nxt = i_imr_run ? ST_IMR : ST_IDRFR;
			ST_IDRFR: state_nxt = ST_EX;
			ST_EX:    state_nxt = i_illegal ? ST_PC : ST_WB;
			default:  state_nxt = ST_PC;
		endcase
	end

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			run_r   <= 1'b0;
			quit_r  <= 1'b0;
			state_r <= ST_PC;
		end else begin
			if (i_cpu_start)
				run_r <= 1'b1;
			else if (stop_wb || stop_ill)
				run_r <= 1'b0;
			if (i_cpu_start || stop_wb || stop_ill)
				quit_r <= 1'b0;
			else if (i_quit_cmd && run_r)
				quit_r <= 1'b1; // remember quit until WB
			state_r <= state_nxt;
		end
	end

	assign o_cpu_run_state = run_r;
	assign o_state         = state_r;

endmodule

/* rtl/cpu_pkg.sv */
package cpu_pkg;

	localparam int XLEN = 32; // data word width

	// instruction sequencer states
	typedef enum logic [2:0] {
		ST_PC    = 3'd0,
		ST_IMR   = 3'd1,
		ST_IDRFR = 3'd2,
		ST_EX    = 3'd3,
		ST_WB    = 3'd4
	} cpu_state_t;

	typedef enum logic [3:0] {
		ALU_ADD  = 4'd0,
		ALU_SUB  = 4'd1,
		ALU_SLL  = 4'd2,
		ALU_SLT  = 4'd3,
		ALU_SLTU = 4'd4,
		ALU_XOR  = 4'd5,
		ALU_SRL  = 4'd6,
		ALU_SRA  = 4'd7,
		ALU_OR   = 4'd8,
		ALU_AND  = 4'd9
	} alu_op_t;

	// funct3 of the branch group
	typedef enum logic [2:0] {
		BR_EQ  = 3'b000,
		BR_NE  = 3'b001,
		BR_LT  = 3'b100,
		BR_GE  = 3'b101,
		BR_LTU = 3'b110,
		BR_GEU = 3'b111
	} br_code_t;

	localparam logic [6:0] OP_LUI   = 7'b0110111;
	localparam logic [6:0] OP_AUIPC = 7'b0010111;
	localparam logic [6:0] OP_JAL   = 7'b1101111;
	localparam logic [6:0] OP_JALR  = 7'b1100111;
	localparam logic [6:0] OP_BR    = 7'b1100011;
	localparam logic [6:0] OP_ALUI  = 7'b0010011; // register-immediate group
	localparam logic [6:0] OP_ALU   = 7'b0110011; // register-register group

endpackage
